// ==== verilog/dma_pkg.sv ====
package dma_pkg;

    // word address, word count and memory word widths
    localparam int ADDR_W = 16;
    localparam int LEN_W = 16;
    localparam int DATA_W = 32;

    // reads in flight, also the pending-address queue depth
    localparam int PIPE_DEPTH = 4;
    localparam int QPTR_W = $clog2(PIPE_DEPTH);
    localparam int QCNT_W = $clog2(PIPE_DEPTH + 1);

    // descriptor is four words: src, dst, len, next/flags
    localparam int DESC_WORDS = 4;
    localparam int DESC_IDX_W = $clog2(DESC_WORDS);

    // word3 layout, next pointer sits above the two flag bits
    localparam int IRQ_COMPLETE_BIT = 0;
    localparam int IRQ_EACH_BIT = 1;
    localparam int NEXT_LSB = 2;

    // irq pulse length
    localparam int IRQ_CYCLES = 2;
    localparam int IRQ_CNT_W = $clog2(IRQ_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_BUSY
    } dma_state_e;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_REQ,
        PH_WAIT_ACK_LOW,
        PH_DONE
    } fetch_phase_e;

    // transfer source, taken from desc_mode at start
    typedef enum logic {
        MODE_DIRECT,
        MODE_DESC
    } dma_mode_e;

    typedef struct packed {
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [LEN_W-1:0]  len;
        // zero ends the chain
        logic [ADDR_W-1:0] next;
        logic              irq_on_each;
        logic              irq_on_complete;
    } dma_desc_t;

endpackage

// ==== verilog/dma_ifs.sv ====
`timescale 1ns/1ps

// copy command from controller to read issuer
interface copy_cmd_if;
    import dma_pkg::*;

    // one-cycle pulse, other fields valid with it
    logic              go;
    logic [ADDR_W-1:0] first_src;
    logic [ADDR_W-1:0] first_dst;
    logic [LEN_W-1:0]  len;
    logic              forward;
    // high while nothing is left to issue
    logic              issued_all;

    modport controller (
        output go, first_src, first_dst, len, forward,
        input  issued_all
    );

    modport issuer (
        input  go, first_src, first_dst, len, forward,
        output issued_all
    );
endinterface

// write addresses from read issuer into the write-back queue
interface wb_queue_if;
    import dma_pkg::*;

    logic              push;
    logic [ADDR_W-1:0] push_addr;
    // fewer than PIPE_DEPTH entries held
    logic              room;
    logic              empty;

    modport issuer (
        output push, push_addr,
        input  room, empty
    );

    modport queue (
        input  push, push_addr,
        output room, empty
    );
endinterface

// ==== verilog/dma_desc_decoder.sv ====
`timescale 1ns/1ps

module dma_desc_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         fetch_go,
    input  logic [dma_pkg::ADDR_W-1:0]   fetch_ptr,
    output logic                         desc_req,
    output logic [dma_pkg::ADDR_W-1:0]   desc_addr,
    input  logic                         desc_ack,
    input  logic [dma_pkg::DATA_W-1:0]   desc_data,
    output logic                         desc_valid,
    output dma_pkg::dma_desc_t           desc
);
    import dma_pkg::*;

    fetch_phase_e          phase;
    logic [DESC_IDX_W-1:0] word_idx;
    logic [ADDR_W-1:0]     base;
    logic                  last_word;
    // words 0..2 kept raw, word3 parsed as it arrives
    logic [DATA_W-1:0]     words [DESC_WORDS-1];
    logic [ADDR_W-1:0]     next_ptr;
    logic                  flag_each;
    logic                  flag_complete;

    assign last_word = (word_idx == DESC_IDX_W'(DESC_WORDS - 1));
    // address held steady from req rise to ack
    assign desc_addr = base + ADDR_W'(word_idx);
    assign desc_valid = (phase == PH_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= PH_IDLE;
            word_idx <= '0;
            desc_req <= 1'b0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (fetch_go) begin
                        word_idx <= '0;
                        desc_req <= 1'b1;
                        phase    <= PH_REQ;
                    end
                end
                PH_REQ: begin
                    // word captured below, drop req
                    if (desc_ack) begin
                        desc_req <= 1'b0;
                        phase    <= PH_WAIT_ACK_LOW;
                    end
                end
                PH_WAIT_ACK_LOW: begin
                    // next req only once ack is back low
                    if (!desc_ack) begin
                        if (last_word) begin
                            phase <= PH_DONE;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            desc_req <= 1'b1;
                            phase    <= PH_REQ;
                        end
                    end
                end
                PH_DONE: begin
                    phase <= PH_IDLE;
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && fetch_go) begin
            base <= fetch_ptr;
        end
        if (phase == PH_REQ && desc_ack) begin
            if (last_word) begin
                next_ptr      <= desc_data[NEXT_LSB +: ADDR_W];
                flag_each     <= desc_data[IRQ_EACH_BIT];
                flag_complete <= desc_data[IRQ_COMPLETE_BIT];
            end else begin
                words[word_idx] <= desc_data;
            end
        end
    end

    always_comb begin
        desc.src             = words[0][ADDR_W-1:0];
        desc.dst             = words[1][ADDR_W-1:0];
        desc.len             = words[2][LEN_W-1:0];
        desc.next            = next_ptr;
        desc.irq_on_each     = flag_each;
        desc.irq_on_complete = flag_complete;
    end

endmodule

// ==== verilog/dma_controller.sv ====
`timescale 1ns/1ps

module dma_controller (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic                         desc_mode,
    input  logic [dma_pkg::ADDR_W-1:0]   src,
    input  logic [dma_pkg::ADDR_W-1:0]   dst,
    input  logic [dma_pkg::LEN_W-1:0]    len,
    input  logic [dma_pkg::ADDR_W-1:0]   desc_ptr,
    output logic                         fetch_go,
    output logic [dma_pkg::ADDR_W-1:0]   fetch_ptr,
    input  logic                         desc_valid,
    input  dma_pkg::dma_desc_t           desc,
    copy_cmd_if.controller               cmd,
    input  logic                         empty,
    output logic                         done,
    output logic                         irq
);
    import dma_pkg::*;

    dma_state_e           state;
    dma_mode_e            mode;
    logic                 from_desc;
    logic [IRQ_CNT_W-1:0] irq_cnt;
    // flags of the descriptor being copied
    logic [ADDR_W-1:0]    cur_next;
    logic                 cur_each;
    logic                 cur_complete;
    // command fields, ports in IDLE, descriptor otherwise
    logic [ADDR_W-1:0]    sel_src;
    logic [ADDR_W-1:0]    sel_dst;
    logic [LEN_W-1:0]     sel_len;
    logic [ADDR_W:0]      src_end;
    logic                 backward;
    logic                 load;
    logic                 finish;
    logic                 chain;

    assign mode = dma_mode_e'(desc_mode);

    always_comb begin
        if (state == ST_IDLE) begin
            sel_src = src;
            sel_dst = dst;
            sel_len = len;
        end else begin
            sel_src = desc.src;
            sel_dst = desc.dst;
            sel_len = desc.len;
        end
    end

    // one past the source end, extra bit so it cannot wrap
    assign src_end = {1'b0, sel_src} + (ADDR_W + 1)'(sel_len);
    // dst above src and inside the source region: copy from the top down
    assign backward = (sel_dst > sel_src) && (src_end > {1'b0, sel_dst});

    assign load = (state == ST_IDLE && start && mode == MODE_DIRECT)
                || (state == ST_FETCH && desc_valid);
    assign finish = (state == ST_BUSY) && cmd.issued_all && empty;
    assign chain = finish && from_desc && (cur_next != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            done      <= 1'b0;
            irq       <= 1'b0;
            irq_cnt   <= '0;
            fetch_go  <= 1'b0;
            cmd.go    <= 1'b0;
            from_desc <= 1'b0;
        end else begin
            fetch_go <= 1'b0;
            cmd.go   <= 1'b0;
            // irq trails the counter by one cycle
            irq <= (irq_cnt != '0);
            if (irq_cnt != '0) begin
                irq_cnt <= irq_cnt - 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        done <= 1'b0;
                        if (mode == MODE_DESC) begin
                            fetch_go  <= 1'b1;
                            from_desc <= 1'b1;
                            state     <= ST_FETCH;
                        end else if (len == '0) begin
                            // nothing to move
                            done      <= 1'b1;
                            from_desc <= 1'b0;
                        end else begin
                            cmd.go    <= 1'b1;
                            from_desc <= 1'b0;
                            state     <= ST_BUSY;
                        end
                    end
                end
                ST_FETCH: begin
                    if (desc_valid) begin
                        cmd.go <= 1'b1;
                        state  <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (chain) begin
                        if (cur_each) begin
                            irq_cnt <= IRQ_CNT_W'(IRQ_CYCLES);
                        end
                        fetch_go <= 1'b1;
                        state    <= ST_FETCH;
                    end else if (finish) begin
                        if (from_desc && cur_complete) begin
                            irq_cnt <= IRQ_CNT_W'(IRQ_CYCLES);
                        end
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            fetch_ptr <= desc_ptr;
        end else if (chain) begin
            fetch_ptr <= cur_next;
        end
        if (load) begin
            cmd.len     <= sel_len;
            cmd.forward <= !backward;
            // backward copy starts at the last word of each region
            cmd.first_src <= backward ? ADDR_W'(src_end - 1'b1) : sel_src;
            cmd.first_dst <= backward ? sel_dst + ADDR_W'(sel_len) - 1'b1 : sel_dst;
        end
        if (state == ST_FETCH && desc_valid) begin
            cur_next     <= desc.next;
            cur_each     <= desc.irq_on_each;
            cur_complete <= desc.irq_on_complete;
        end
    end

endmodule

// ==== verilog/dma_read_issue.sv ====
`timescale 1ns/1ps

module dma_read_issue (
    input  logic                         clk,
    input  logic                         rst_n,
    copy_cmd_if.issuer                   cmd,
    wb_queue_if.issuer                   wbq,
    output logic                         mem_read_en,
    output logic [dma_pkg::ADDR_W-1:0]   mem_read_addr
);
    import dma_pkg::*;

    logic [ADDR_W-1:0] rd_idx;
    logic [ADDR_W-1:0] wr_idx;
    logic [LEN_W-1:0]  remaining;
    logic              forward;
    logic              issue;

    // one read per cycle while words remain and the queue can take the address
    assign issue = (remaining != '0) && wbq.room;

    // paired write address goes into the queue with the read
    assign wbq.push = issue;
    assign wbq.push_addr = wr_idx;

    // go masks the stale zero count until the new one is loaded
    assign cmd.issued_all = (remaining == '0) && !cmd.go;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining   <= '0;
            mem_read_en <= 1'b0;
        end else begin
            mem_read_en <= issue;
            if (cmd.go) begin
                remaining <= cmd.len;
            end else if (issue) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.go) begin
            rd_idx  <= cmd.first_src;
            wr_idx  <= cmd.first_dst;
            forward <= cmd.forward;
        end else if (issue) begin
            mem_read_addr <= rd_idx;
            // both indices step the same way
            if (forward) begin
                rd_idx <= rd_idx + 1'b1;
                wr_idx <= wr_idx + 1'b1;
            end else begin
                rd_idx <= rd_idx - 1'b1;
                wr_idx <= wr_idx - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/dma_write_back.sv ====
`timescale 1ns/1ps

module dma_write_back (
    input  logic                         clk,
    input  logic                         rst_n,
    wb_queue_if.queue                    wbq,
    input  logic [dma_pkg::DATA_W-1:0]   mem_read_data,
    input  logic                         mem_read_valid,
    output logic                         mem_write_en,
    output logic [dma_pkg::ADDR_W-1:0]   mem_write_addr,
    output logic [dma_pkg::DATA_W-1:0]   mem_write_data
);
    import dma_pkg::*;

    // circular queue of write addresses, one per read in flight
    logic [ADDR_W-1:0] pend_addr [PIPE_DEPTH];
    logic [QPTR_W-1:0] head;
    logic [QPTR_W-1:0] tail;
    logic [QCNT_W-1:0] count;

    assign wbq.room = (count < QCNT_W'(PIPE_DEPTH));
    assign wbq.empty = (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            mem_write_en <= 1'b0;
        end else begin
            // read data returns in issue order, oldest address first
            mem_write_en <= mem_read_valid;
            if (wbq.push) begin
                tail <= tail + 1'b1;
            end
            if (mem_read_valid) begin
                head <= head + 1'b1;
            end
            // push and pop in one cycle leave the count alone
            case ({wbq.push, mem_read_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wbq.push) begin
            pend_addr[tail] <= wbq.push_addr;
        end
        if (mem_read_valid) begin
            mem_write_addr <= pend_addr[head];
            mem_write_data <= mem_read_data;
        end
    end

endmodule

// ==== verilog/dma_top.sv ====
`timescale 1ns/1ps

module dma_top (
    input  logic                         clk,
    input  logic                         rst_n,
    // control and status
    input  logic                         start,
    input  logic                         desc_mode,
    input  logic [dma_pkg::ADDR_W-1:0]   src,
    input  logic [dma_pkg::ADDR_W-1:0]   dst,
    input  logic [dma_pkg::LEN_W-1:0]    len,
    input  logic [dma_pkg::ADDR_W-1:0]   desc_ptr,
    output logic                         done,
    output logic                         irq,
    // memory read side, data one cycle after the request
    output logic                         mem_read_en,
    output logic [dma_pkg::ADDR_W-1:0]   mem_read_addr,
    input  logic [dma_pkg::DATA_W-1:0]   mem_read_data,
    input  logic                         mem_read_valid,
    // memory write side
    output logic                         mem_write_en,
    output logic [dma_pkg::ADDR_W-1:0]   mem_write_addr,
    output logic [dma_pkg::DATA_W-1:0]   mem_write_data,
    // descriptor port, four-phase req/ack
    output logic                         desc_req,
    output logic [dma_pkg::ADDR_W-1:0]   desc_addr,
    input  logic                         desc_ack,
    input  logic [dma_pkg::DATA_W-1:0]   desc_data
);
    import dma_pkg::*;

    logic              fetch_go;
    logic [ADDR_W-1:0] fetch_ptr;
    logic              desc_valid;
    dma_desc_t         desc;

    copy_cmd_if i_cmd_if ();
    wb_queue_if i_wbq_if ();

    dma_controller i_controller (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .desc_mode  (desc_mode),
        .src        (src),
        .dst        (dst),
        .len        (len),
        .desc_ptr   (desc_ptr),
        .fetch_go   (fetch_go),
        .fetch_ptr  (fetch_ptr),
        .desc_valid (desc_valid),
        .desc       (desc),
        .cmd        (i_cmd_if.controller),
        .empty      (i_wbq_if.empty),
        .done       (done),
        .irq        (irq)
    );

    dma_desc_decoder i_desc_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_go   (fetch_go),
        .fetch_ptr  (fetch_ptr),
        .desc_req   (desc_req),
        .desc_addr  (desc_addr),
        .desc_ack   (desc_ack),
        .desc_data  (desc_data),
        .desc_valid (desc_valid),
        .desc       (desc)
    );

    dma_read_issue i_read_issue (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (i_cmd_if.issuer),
        .wbq           (i_wbq_if.issuer),
        .mem_read_en   (mem_read_en),
        .mem_read_addr (mem_read_addr)
    );

    dma_write_back i_write_back (
        .clk            (clk),
        .rst_n          (rst_n),
        .wbq            (i_wbq_if.queue),
        .mem_read_data  (mem_read_data),
        .mem_read_valid (mem_read_valid),
        .mem_write_en   (mem_write_en),
        .mem_write_addr (mem_write_addr),
        .mem_write_data (mem_write_data)
    );

endmodule

// ==== dv/dma_tb_mem.sv ====
`timescale 1ns/1ps

module dma_tb_mem (
    input  logic                         clk,
    input  logic                         rst_n,
    // DMA read side, data one cycle after the request
    input  logic                         mem_read_en,
    input  logic [dma_pkg::ADDR_W-1:0]   mem_read_addr,
    output logic [dma_pkg::DATA_W-1:0]   mem_read_data,
    output logic                         mem_read_valid,
    // DMA write side
    input  logic                         mem_write_en,
    input  logic [dma_pkg::ADDR_W-1:0]   mem_write_addr,
    input  logic [dma_pkg::DATA_W-1:0]   mem_write_data,
    // descriptor responder, four-phase
    input  logic                         desc_req,
    input  logic [dma_pkg::ADDR_W-1:0]   desc_addr,
    output logic                         desc_ack,
    output logic [dma_pkg::DATA_W-1:0]   desc_data,
    // testbench port for placing descriptors
    input  logic                         load_en,
    input  logic [dma_pkg::ADDR_W-1:0]   load_addr,
    input  logic [dma_pkg::DATA_W-1:0]   load_data
);
    import dma_pkg::*;

    // one word per possible word address
    logic [DATA_W-1:0] mem [2**ADDR_W];
    integer            seed;

    // random contents so every copied word is distinct
    initial begin
        seed = 32'hae8c_d2cb;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] <= $random(seed);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_read_valid <= 1'b0;
            desc_ack       <= 1'b0;
        end else begin
            mem_read_valid <= mem_read_en;
            // ack answers a waiting req, drops once req is gone
            if (desc_req && !desc_ack) begin
                desc_ack <= 1'b1;
            end else if (!desc_req) begin
                desc_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (mem_write_en) begin
            mem[mem_write_addr] <= mem_write_data;
        end
        if (mem_read_en) begin
            mem_read_data <= mem[mem_read_addr];
        end
        // data held valid for the whole ack high phase
        if (desc_req && !desc_ack) begin
            desc_data <= mem[desc_addr];
        end
    end

endmodule

// ==== dv/dma_assertions.sv ====
`timescale 1ns/1ps

module dma_assertions (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         desc_req,
    input  logic [dma_pkg::ADDR_W-1:0]   desc_addr,
    input  logic                         desc_ack,
    input  logic                         irq
);
    import dma_pkg::*;

    // address must not move while a request waits for ack
    a_desc_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (desc_req && !desc_ack) |=> (!desc_req || $stable(desc_addr)))
        else $error("desc_addr changed while desc_req waited for desc_ack");

    // new request only after ack is back low
    a_req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(desc_req) |-> !desc_ack)
        else $error("desc_req rose while desc_ack was still high");

    // irq pulse no longer than IRQ_CYCLES
    a_irq_length: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(irq) |-> ##IRQ_CYCLES !irq)
        else $error("irq stayed high longer than its pulse length");

endmodule

bind dma_top dma_assertions i_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .desc_req  (desc_req),
    .desc_addr (desc_addr),
    .desc_ack  (desc_ack),
    .irq       (irq)
);

// ==== dv/dma_tb.sv ====
`timescale 1ns/1ps

module dma_tb;
    import dma_pkg::*;

    localparam int MEM_WORDS = 2 ** ADDR_W;
    localparam int N_RUNS = 6;
    localparam int N_DESCS = 3;

    // one transfer: len_ptr is the length in direct mode, the chain head otherwise
    typedef struct packed {
        dma_mode_e         mode;
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [LEN_W-1:0]  len_ptr;
        logic [3:0]        irqs;
    } run_t;

    // descriptor image placed in memory before its run
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] next;
        logic              each;
        logic              complete;
    } desc_row_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              start;
    logic              desc_mode;
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    logic [LEN_W-1:0]  len;
    logic [ADDR_W-1:0] desc_ptr;
    logic              done;
    logic              irq;
    logic              mem_read_en;
    logic [ADDR_W-1:0] mem_read_addr;
    logic [DATA_W-1:0] mem_read_data;
    logic              mem_read_valid;
    logic              mem_write_en;
    logic [ADDR_W-1:0] mem_write_addr;
    logic [DATA_W-1:0] mem_write_data;
    logic              desc_req;
    logic [ADDR_W-1:0] desc_addr;
    logic              desc_ack;
    logic [DATA_W-1:0] desc_data;
    logic              load_en;
    logic [ADDR_W-1:0] load_addr;
    logic [DATA_W-1:0] load_data;

    run_t              runs [N_RUNS];
    desc_row_t         descs [N_DESCS];
    // expected memory after each run
    logic [DATA_W-1:0] shadow [MEM_WORDS];
    int                cycles = 0;
    int                limit = 0;
    int                irq_pulses = 0;
    int                irq_high = 0;
    int                read_cycles = 0;
    int                write_cycles = 0;

    always #50 clk = ~clk;

    dma_top i_dut (.*);

    dma_tb_mem i_mem (.*);

    // run length guard
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the DUT did not finish within %0d cycles", limit);
            $display("test failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // count irq pulses and check each one's width
    always @(negedge clk) begin
        if (irq) begin
            irq_high++;
        end else if (irq_high != 0) begin
            check_value("irq pulse length", DATA_W'(irq_high), DATA_W'(IRQ_CYCLES));
            irq_pulses++;
            irq_high = 0;
        end
    end

    // word traffic on both memory ports
    always @(negedge clk) begin
        if (mem_read_en) begin
            read_cycles++;
        end
        if (mem_write_en) begin
            write_cycles++;
        end
    end

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic fill_tables();
        // non-overlapping, backward overlap, forward overlap, zero length
        runs[0] = '{MODE_DIRECT, 16'h0010, 16'h0100, 16'd24, 4'd0};
        runs[1] = '{MODE_DIRECT, 16'h0200, 16'h0201, 16'd20, 4'd0};
        runs[2] = '{MODE_DIRECT, 16'h0301, 16'h0300, 16'd20, 4'd0};
        runs[3] = '{MODE_DIRECT, 16'h0400, 16'h0500, 16'd0, 4'd0};
        // two-descriptor chain, then a lone descriptor with no flags
        runs[4] = '{MODE_DESC, 16'h0000, 16'h0000, 16'h0800, 4'd2};
        runs[5] = '{MODE_DESC, 16'h0000, 16'h0000, 16'h0900, 4'd0};
        descs[0] = '{16'h0800, 16'h0600, 16'h0640, 16'd16, 16'h0810, 1'b1, 1'b0};
        descs[1] = '{16'h0810, 16'h0620, 16'h0628, 16'd12, 16'h0000, 1'b0, 1'b1};
        descs[2] = '{16'h0900, 16'h0700, 16'h06f8, 16'd10, 16'h0000, 1'b0, 1'b0};
    endtask

    function automatic int desc_index(input logic [ADDR_W-1:0] addr);
        desc_index = -1;
        for (int i = 0; i < N_DESCS; i++) begin
            if (descs[i].addr == addr) begin
                desc_index = i;
            end
        end
    endfunction

    // 8 cycles a word, 40 more per descriptor
    function automatic int cycle_budget(input run_t r);
        int idx;
        int sum;
        sum = 0;
        if (r.mode == MODE_DESC) begin
            idx = desc_index(r.len_ptr);
            while (idx >= 0) begin
                sum += 8 * int'(descs[idx].len) + 40;
                idx = (descs[idx].next == '0) ? -1 : desc_index(descs[idx].next);
            end
        end else begin
            sum = 8 * int'(r.len_ptr);
        end
        return sum;
    endfunction

    // memmove: read the whole source before any write
    task automatic ref_memmove(input logic [ADDR_W-1:0] s, input logic [ADDR_W-1:0] d,
                               input logic [LEN_W-1:0] n);
        logic [DATA_W-1:0] tmp [$];
        for (int i = 0; i < int'(n); i++) begin
            tmp.push_back(shadow[s + ADDR_W'(i)]);
        end
        for (int i = 0; i < int'(n); i++) begin
            shadow[d + ADDR_W'(i)] = tmp[i];
        end
    endtask

    task automatic load_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] v);
        load_en   = 1'b1;
        load_addr = a;
        load_data = v;
        shadow[a] = v;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // word3 holds next in bits 17..2, irq_on_each in bit 1, irq_on_complete in bit 0
    task automatic write_desc(input desc_row_t e);
        load_word(e.addr, DATA_W'(e.src));
        load_word(e.addr + ADDR_W'(1), DATA_W'(e.dst));
        load_word(e.addr + ADDR_W'(2), DATA_W'(e.len));
        load_word(e.addr + ADDR_W'(3),
                  {{(DATA_W-ADDR_W-NEXT_LSB){1'b0}}, e.next, e.each, e.complete});
    endtask

    task automatic compare_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("mem[%0h]", i), i_mem.mem[i], shadow[i]);
        end
    endtask

    task automatic apply_run(input run_t r);
        int idx;
        int pulses_before;
        int reads_before;
        int writes_before;
        int words;
        words = 0;
        if (r.mode == MODE_DESC) begin
            idx = desc_index(r.len_ptr);
            while (idx >= 0) begin
                write_desc(descs[idx]);
                ref_memmove(descs[idx].src, descs[idx].dst, descs[idx].len);
                words += int'(descs[idx].len);
                idx = (descs[idx].next == '0) ? -1 : desc_index(descs[idx].next);
            end
        end else begin
            ref_memmove(r.src, r.dst, r.len_ptr);
            words = int'(r.len_ptr);
        end
        pulses_before = irq_pulses;
        reads_before  = read_cycles;
        writes_before = write_cycles;
        desc_mode = r.mode;
        src       = r.src;
        dst       = r.dst;
        len       = r.len_ptr;
        desc_ptr  = r.len_ptr;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // accepted start clears done, a zero-length copy sets it again at once
        check_value("done after start", DATA_W'(done),
                    DATA_W'(r.mode == MODE_DIRECT && r.len_ptr == '0));
        while (!done) begin
            @(negedge clk);
        end
        // trailing irq starts one cycle after completion
        repeat (IRQ_CYCLES + 3) @(negedge clk);
        check_value("irq pulse count", DATA_W'(irq_pulses - pulses_before), DATA_W'(r.irqs));
        // each word read once and written once
        check_value("mem_read_en cycles", DATA_W'(read_cycles - reads_before),
                    DATA_W'(words));
        check_value("mem_write_en cycles", DATA_W'(write_cycles - writes_before),
                    DATA_W'(words));
        check_value("done", DATA_W'(done), DATA_W'(1));
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        desc_mode = 1'b0;
        src       = '0;
        dst       = '0;
        len       = '0;
        desc_ptr  = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        fill_tables();
        limit = 200;
        for (int n = 0; n < N_RUNS; n++) begin
            limit += cycle_budget(runs[n]);
        end
        // memory fills itself at time zero
        #1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = i_mem.mem[i];
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // outputs quiet out of reset
        check_value("done", DATA_W'(done), DATA_W'(0));
        check_value("irq", DATA_W'(irq), DATA_W'(0));
        check_value("mem_read_en", DATA_W'(mem_read_en), DATA_W'(0));
        check_value("mem_write_en", DATA_W'(mem_write_en), DATA_W'(0));
        check_value("desc_req", DATA_W'(desc_req), DATA_W'(0));
        for (int n = 0; n < N_RUNS; n++) begin
            apply_run(runs[n]);
            compare_memory();
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== project.f ====
verilog/dma_pkg.sv
verilog/dma_ifs.sv
verilog/dma_desc_decoder.sv
verilog/dma_controller.sv
verilog/dma_read_issue.sv
verilog/dma_write_back.sv
verilog/dma_top.sv
dv/dma_tb_mem.sv
dv/dma_assertions.sv
dv/dma_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the DMA testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module dma_tb -f project.f -o dma_sim &&
./obj_dir/dma_sim | tee /dev/stderr | grep -qx "test passed" &&
echo "simulation ok" ||
{ echo "simulation not ok"; exit 1; }
